// File: design/gpr_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "wb_params.svh"

module gpr_file (
   input  wire logic                      clk,
   input  wire logic                      rst,
   input  wire wb_pkg::gpr_write_t        gpr_wr,
   input  wire wb_pkg::gpr_write_t        gpr_wr_2,
   input  wire logic [`WB_GPR_IDX_W-1:0]  rd_index,
   output logic [`WB_GPR_W-1:0]           rd_data
);

   import wb_pkg::*;

   logic [`WB_GPR_W-1:0]     regs      [`WB_NUM_GPR];
   logic [`WB_GPR_W-1:0]     regs_next [`WB_NUM_GPR];
   logic [`WB_GPR_IDX_W-1:0] hi_byte_idx;

   // AH/CH/DH/BH live in bits 15:8 of registers 0-3
   assign hi_byte_idx = {1'b0, gpr_wr.index[1:0]};

   always_comb begin
      regs_next = regs;

      // port 1 honours the operand size
      if (gpr_wr.en) begin
         case (gpr_wr.size)
            size_byte: begin
               if (gpr_wr.index[2]) begin
                  regs_next[hi_byte_idx][15:8] = gpr_wr.data[7:0];
               end else begin
                  regs_next[gpr_wr.index][7:0] = gpr_wr.data[7:0];
               end
            end
            size_word: begin
               regs_next[gpr_wr.index][15:0] = gpr_wr.data[15:0];
            end
            default: begin
               regs_next[gpr_wr.index] = gpr_wr.data;
            end
         endcase
      end

      // port 2 lands last, so it wins on the same index
      if (gpr_wr_2.en) begin
         regs_next[gpr_wr_2.index] = gpr_wr_2.data;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `WB_NUM_GPR; i++) begin
            regs[i] <= '0;
         end
      end else begin
         regs <= regs_next;
      end
   end

   // combinational debug read
   assign rd_data = regs[rd_index];

endmodule

`default_nettype wire

// File: design/gpr_write_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

`include "wb_params.svh"

module gpr_write_arbiter #(
   parameter int DEPTH = `WB_QUEUE_DEPTH
) (
   input  wire logic            clk,
   input  wire logic            rst,
   input  wire wb_pkg::dec_wb_t dec_wb,
   input  wire wb_pkg::commit_t commit,
   output wb_pkg::gpr_write_t   gpr_wr,
   output wb_pkg::gpr_write_t   gpr_wr_2
);

   import wb_pkg::*;

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   commit_t          queue [DEPTH];
   logic [PTR_W-1:0] head;
   logic [PTR_W-1:0] tail;
   logic [CNT_W-1:0] count;

   logic q_empty;
   logic push;
   logic pop;

   // wraps for depths that are not a power of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      logic [PTR_W-1:0] nxt;
      if (ptr == PTR_W'(DEPTH - 1)) begin
         nxt = '0;
      end else begin
         nxt = ptr + 1'b1;
      end
      return nxt;
   endfunction

   assign q_empty = (count == '0);

   // a commit waits whenever decode owns the port or older commits are pending
   assign push = commit.valid & (dec_wb.valid | ~q_empty);
   assign pop  = ~dec_wb.valid & ~q_empty;

   always_comb begin
      gpr_wr   = '0;
      gpr_wr_2 = '0;
      if (dec_wb.valid) begin
         gpr_wr.en    = 1'b1;
         gpr_wr.index = dec_wb.index;
         gpr_wr.size  = dec_wb.size;
         gpr_wr.data  = dec_wb.data;
      end else if (!q_empty) begin
         gpr_wr   = queue[head].primary;
         gpr_wr_2 = queue[head].secondary;
      end else if (commit.valid) begin
         // with nothing ahead the commit writes through in the same cycle
         gpr_wr   = commit.primary;
         gpr_wr_2 = commit.secondary;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
      end else begin
         if (push) begin
            tail <= ptr_inc(tail);
         end
         if (pop) begin
            head <= ptr_inc(head);
         end
         // push and pop together leave the occupancy unchanged
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         queue[tail] <= commit;
      end
   end

endmodule

`default_nettype wire

// File: design/wb_params.svh
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

// general register file
`define WB_NUM_GPR       8
`define WB_GPR_IDX_W     3
`define WB_GPR_W         32

// memory write port
`define WB_ADDR_W        32
`define WB_RESULT_W      64
`define WB_BYTE_EN_W     8

// execute stage operation codes
`define WB_ALU_OP_W      4
`define WB_ALU_XCHG      4'd14

// deferral queue between execute commits and the register file
`define WB_QUEUE_DEPTH   4

`endif

// File: design/wb_pkg.sv
`default_nettype none

`include "wb_params.svh"

package wb_pkg;

   // operand size as carried down the pipe
   typedef enum logic [1:0] {
      size_byte  = 2'd0,
      size_word  = 2'd1,
      size_dword = 2'd2,
      size_qword = 2'd3
   } op_size_e;

   typedef struct packed {
      logic [`WB_GPR_W-1:0] hi;
      logic [`WB_GPR_W-1:0] lo;
   } wb_halves_t;

   // exchange splits the result, memory writes take it whole
   typedef union packed {
      logic [`WB_RESULT_W-1:0] raw;
      wb_halves_t              halves;
   } wb_result_u;

   // one committed result from execute
   typedef struct packed {
      logic                      valid;
      logic [`WB_ALU_OP_W-1:0]   alu_op;
      op_size_e                  size;
      wb_result_u                result;
      logic                      op_a_is_reg;
      logic [`WB_GPR_IDX_W-1:0]  op_a_reg;
      logic                      op_a_is_address;
      logic [`WB_ADDR_W-1:0]     op_a_address;
      logic                      op_b_is_reg;
      logic [`WB_GPR_IDX_W-1:0]  op_b_reg;
      logic                      op_b_is_address;
      logic [`WB_ADDR_W-1:0]     op_b_address;
   } exe_result_t;

   // register write issued straight from decode
   typedef struct packed {
      logic                      valid;
      logic [`WB_GPR_IDX_W-1:0]  index;
      op_size_e                  size;
      logic [`WB_GPR_W-1:0]      data;
   } dec_wb_t;

   typedef struct packed {
      logic                      en;
      logic [`WB_GPR_IDX_W-1:0]  index;
      op_size_e                  size;
      logic [`WB_GPR_W-1:0]      data;
   } gpr_write_t;

   // secondary carries the op_b half of an exchange
   typedef struct packed {
      logic                      valid;
      gpr_write_t                primary;
      gpr_write_t                secondary;
   } commit_t;

   typedef struct packed {
      logic                      valid;
      logic [`WB_ADDR_W-1:0]     address;
      logic [`WB_RESULT_W-1:0]   data;
      logic [`WB_BYTE_EN_W-1:0]  byte_en;
   } mem_write_t;

endpackage

`default_nettype wire

// File: design/wb_router.sv
`timescale 1ns/1ns
`default_nettype none

`include "wb_params.svh"

module wb_router (
   input  wire logic                clk,
   input  wire logic                rst,
   input  wire wb_pkg::exe_result_t exe,
   output wb_pkg::commit_t          commit,
   output wb_pkg::mem_write_t       mem_wr
);

   import wb_pkg::*;

   logic is_xchg;
   logic xchg_to_mem;
   logic mem_hit;

   // low-aligned byte lanes for a memory write
   function automatic logic [`WB_BYTE_EN_W-1:0] size_to_byte_en(input op_size_e size);
      logic [`WB_BYTE_EN_W-1:0] be;
      case (size)
         size_byte:  be = 8'h01;
         size_word:  be = 8'h03;
         size_dword: be = 8'h0f;
         default:    be = 8'hff;
      endcase
      return be;
   endfunction

   assign is_xchg     = (exe.alu_op == `WB_ALU_XCHG);
   // exchange with a memory op_b sends the high half out to memory
   assign xchg_to_mem = is_xchg & exe.op_b_is_address;
   assign mem_hit     = exe.valid & (exe.op_a_is_address | xchg_to_mem);

   // register side goes to the arbiter in the strobe cycle
   always_comb begin
      commit.primary.en    = exe.valid & exe.op_a_is_reg;
      commit.primary.index = exe.op_a_reg;
      commit.primary.data  = exe.result.halves.lo;
      // qword lands as a dword in the 32-bit registers
      if (exe.size == size_qword) begin
         commit.primary.size = size_dword;
      end else begin
         commit.primary.size = exe.size;
      end

      commit.secondary.en    = exe.valid & is_xchg & exe.op_b_is_reg;
      commit.secondary.index = exe.op_b_reg;
      commit.secondary.size  = size_dword;
      commit.secondary.data  = exe.result.halves.hi;

      commit.valid = commit.primary.en | commit.secondary.en;
   end

   // memory strobe follows the exe strobe by one cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         mem_wr.valid <= 1'b0;
      end else begin
         mem_wr.valid <= mem_hit;
      end
   end

   always_ff @(posedge clk) begin
      if (mem_hit) begin
         mem_wr.byte_en <= size_to_byte_en(exe.size);
         if (xchg_to_mem) begin
            mem_wr.address <= exe.op_b_address;
            mem_wr.data    <= {{(`WB_RESULT_W - `WB_GPR_W){1'b0}}, exe.result.halves.hi};
         end else begin
            mem_wr.address <= exe.op_a_address;
            mem_wr.data    <= exe.result.raw;
         end
      end
   end

endmodule

`default_nettype wire

// File: design/writeback_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "wb_params.svh"

module writeback_unit (
   input  wire logic                      clk,
   input  wire logic                      rst,
   input  wire wb_pkg::exe_result_t       exe,
   input  wire wb_pkg::dec_wb_t           dec_wb,
   output wb_pkg::mem_write_t             mem_wr,
   input  wire logic [`WB_GPR_IDX_W-1:0]  rd_index,
   output logic [`WB_GPR_W-1:0]           rd_data
);

   import wb_pkg::*;

   // router to arbiter
   commit_t    commit;

   // arbiter to register file
   gpr_write_t gpr_wr;
   gpr_write_t gpr_wr_2;

   // splits each execute result into register and memory work
   wb_router u_router (
      .clk    (clk),
      .rst    (rst),
      .exe    (exe),
      .commit (commit),
      .mem_wr (mem_wr)
   );

   // decode writes take the port, execute commits queue behind them
   gpr_write_arbiter #(
      .DEPTH (`WB_QUEUE_DEPTH)
   ) u_arbiter (
      .clk      (clk),
      .rst      (rst),
      .dec_wb   (dec_wb),
      .commit   (commit),
      .gpr_wr   (gpr_wr),
      .gpr_wr_2 (gpr_wr_2)
   );

   gpr_file u_gpr (
      .clk      (clk),
      .rst      (rst),
      .gpr_wr   (gpr_wr),
      .gpr_wr_2 (gpr_wr_2),
      .rd_index (rd_index),
      .rd_data  (rd_data)
   );

endmodule

`default_nettype wire

// File: dv/writeback_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "wb_params.svh"

module writeback_unit_tb;

   import wb_pkg::*;

   localparam int DEPTH        = `WB_QUEUE_DEPTH;
   localparam int RESET_CYCLES = 5;
   localparam int NUM_CYCLES   = 2000;
   localparam int DRAIN_CYCLES = 2 * DEPTH;
   localparam int READ_CYCLES  = 2 * `WB_NUM_GPR;
   localparam int TOTAL_CYCLES = RESET_CYCLES + NUM_CYCLES + DRAIN_CYCLES + READ_CYCLES;
   localparam time WATCHDOG_NS = TOTAL_CYCLES * 10 * 2;

   logic                      clk;
   logic                      rst;
   exe_result_t               exe;
   dec_wb_t                   dec_wb;
   mem_write_t                mem_wr;
   logic [`WB_GPR_IDX_W-1:0]  rd_index;
   logic [`WB_GPR_W-1:0]      rd_data;

   integer                    seed;

   // reference model state
   logic [`WB_GPR_W-1:0]      model_regs [`WB_NUM_GPR];
   commit_t                   pending [$];
   mem_write_t                exp_mem;

   writeback_unit u_writeback_unit (
      .clk      (clk),
      .rst      (rst),
      .exe      (exe),
      .dec_wb   (dec_wb),
      .mem_wr   (mem_wr),
      .rd_index (rd_index),
      .rd_data  (rd_data)
   );

   initial begin
      clk = 1'b0;
   end

   always #5 clk = ~clk;

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      if (actual !== expected) begin
         $display("mismatch at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
         $display("RESULT: FAIL");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   function automatic int rand_below(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   // lane rules of a primary port write
   task automatic write_model_reg(input int idx, input op_size_e size,
                                  input logic [`WB_GPR_W-1:0] data);
      if (size == size_byte) begin
         if (idx >= 4) begin
            model_regs[idx - 4][15:8] = data[7:0];
         end else begin
            model_regs[idx][7:0] = data[7:0];
         end
      end else if (size == size_word) begin
         model_regs[idx][15:0] = data[15:0];
      end else begin
         model_regs[idx] = data;
      end
   endtask

   // secondary always lands as a full register, after the primary
   task automatic apply_commit(input commit_t c);
      if (c.primary.en) begin
         write_model_reg(c.primary.index, c.primary.size, c.primary.data);
      end
      if (c.secondary.en) begin
         model_regs[c.secondary.index] = c.secondary.data;
      end
   endtask

   function automatic commit_t expect_commit(input exe_result_t e);
      commit_t c;
      logic    xchg;
      c    = '0;
      xchg = (e.alu_op == `WB_ALU_XCHG);
      if (e.valid && e.op_a_is_reg) begin
         c.primary.en    = 1'b1;
         c.primary.index = e.op_a_reg;
         c.primary.data  = e.result.raw[31:0];
         c.primary.size  = (e.size == size_qword) ? size_dword : e.size;
      end
      if (e.valid && xchg && e.op_b_is_reg) begin
         c.secondary.en    = 1'b1;
         c.secondary.index = e.op_b_reg;
         c.secondary.data  = e.result.raw[63:32];
         c.secondary.size  = size_dword;
      end
      c.valid = c.primary.en || c.secondary.en;
      return c;
   endfunction

   function automatic mem_write_t expect_mem(input exe_result_t e);
      mem_write_t m;
      m = '0;
      if (e.valid) begin
         if (e.alu_op == `WB_ALU_XCHG && e.op_b_is_address) begin
            m.valid   = 1'b1;
            m.address = e.op_b_address;
            m.data    = {32'h0, e.result.raw[63:32]};
         end else if (e.op_a_is_address) begin
            m.valid   = 1'b1;
            m.address = e.op_a_address;
            m.data    = e.result.raw;
         end
         case (e.size)
            size_byte:  m.byte_en = 8'h01;
            size_word:  m.byte_en = 8'h03;
            size_dword: m.byte_en = 8'h0f;
            default:    m.byte_en = 8'hff;
         endcase
      end
      return m;
   endfunction

   // what the next rising edge does with the inputs now driven
   task automatic model_cycle();
      commit_t c;
      commit_t head;
      c = expect_commit(exe);
      if (dec_wb.valid) begin
         write_model_reg(dec_wb.index, dec_wb.size, dec_wb.data);
         if (c.valid) begin
            pending.push_back(c);
         end
      end else if (pending.size() > 0) begin
         head = pending.pop_front();
         apply_commit(head);
         if (c.valid) begin
            pending.push_back(c);
         end
      end else if (c.valid) begin
         apply_commit(c);
      end
      exp_mem = expect_mem(exe);
   endtask

   task automatic drive_random();
      exe_result_t e;
      dec_wb_t     d;
      int          kind_a;
      int          kind_b;
      e.valid  = (rand_below(4) != 0);
      e.alu_op = (rand_below(10) < 3) ? `WB_ALU_XCHG : 4'(rand_below(14));
      e.size   = op_size_e'(rand_below(4));
      e.result.raw = {$random(seed), $random(seed)};
      // 0-3 register, 4-6 memory, 7 neither
      kind_a = rand_below(8);
      kind_b = rand_below(8);
      e.op_a_is_reg     = (kind_a < 4);
      e.op_a_is_address = (kind_a >= 4 && kind_a < 7);
      e.op_a_reg        = 3'(rand_below(8));
      e.op_a_address    = $random(seed);
      e.op_b_is_reg     = (kind_b < 4);
      e.op_b_is_address = (kind_b >= 4 && kind_b < 7);
      e.op_b_reg        = 3'(rand_below(8));
      e.op_b_address    = $random(seed);

      // decode only while the queue cannot overflow
      d.valid = (pending.size() < DEPTH - 1) && (rand_below(10) < 4);
      d.index = 3'(rand_below(8));
      d.size  = op_size_e'(rand_below(4));
      d.data  = $random(seed);

      exe    = e;
      dec_wb = d;
      model_cycle();
   endtask

   task automatic drive_idle();
      exe.valid    = 1'b0;
      dec_wb.valid = 1'b0;
      model_cycle();
   endtask

   task automatic check_mem();
      check_value("mem_wr.valid", mem_wr.valid, exp_mem.valid);
      if (exp_mem.valid) begin
         check_value("mem_wr.address", mem_wr.address, exp_mem.address);
         check_value("mem_wr.data", mem_wr.data, exp_mem.data);
         check_value("mem_wr.byte_en", mem_wr.byte_en, exp_mem.byte_en);
      end
   endtask

   // inputs stay idle, so rd_data is stable between edges
   task automatic read_and_check(input int idx);
      @(posedge clk);
      #1;
      check_mem();
      rd_index = idx;
      #2;
      check_value($sformatf("rd_data[%0d]", idx), rd_data, model_regs[idx]);
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired at %0t ns, the run did not finish", $time);
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
   end

   initial begin
      seed     = 32'ha718_64e6;
      rst      = 1'b1;
      exe      = '0;
      dec_wb   = '0;
      rd_index = '0;
      exp_mem  = '0;
      for (int i = 0; i < `WB_NUM_GPR; i++) begin
         model_regs[i] = '0;
      end

      // a memory strobe held through reset must not reach mem_wr
      exe.valid           = 1'b1;
      exe.op_a_is_address = 1'b1;

      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst = 1'b0;
      exe = '0;

      // everything cleared by reset
      check_value("mem_wr.valid", mem_wr.valid, 1'b0);
      for (int i = 0; i < `WB_NUM_GPR; i++) begin
         read_and_check(i);
      end

      // random traffic, memory strobes checked every cycle
      for (int n = 0; n < NUM_CYCLES; n++) begin
         @(posedge clk);
         #1;
         check_mem();
         drive_random();
      end

      // let the deferral queue empty out
      for (int n = 0; n < DRAIN_CYCLES; n++) begin
         @(posedge clk);
         #1;
         check_mem();
         drive_idle();
      end

      for (int i = 0; i < `WB_NUM_GPR; i++) begin
         read_and_check(i);
      end

      $display("RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: wb_unit.f
+incdir+design
design/wb_pkg.sv
design/wb_router.sv
design/gpr_write_arbiter.sv
design/gpr_file.sv
design/writeback_unit.sv
dv/writeback_unit_tb.sv
